// File: src/cpuPkg.sv
/* Shared types for the 8-bit core: opcodes, ALU operations, control word,
   instruction views and the register and memory write ports */
package cpuPkg;

    localparam int DATA_W     = 8;                         // Register and memory word
    localparam int REG_ADDR_W = 3;                         // Eight registers
    localparam int PC_W       = 32;
    localparam int PC_STEP    = 4;                         // Bytes per instruction

    // ================================================
    // Encodings
    // ================================================
    typedef enum logic [7:0] {
        OP_LOADI, OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR,
        OP_J, OP_BEQ, OP_LWD, OP_LWI, OP_SWD, OP_SWI
    } opcodeE;                                             // 12 to 255 run as no-ops

    typedef enum logic [1:0] {ALU_FWD, ALU_ADD, ALU_AND, ALU_OR} aluOpE;

    typedef enum logic [1:0] {PC_SEQ, PC_JUMP, PC_BEQ} pcSelE;

    typedef struct packed {
        aluOpE aluOp;
        logic  negate;                                     // Two's complement of operand two
        logic  useImm;                                     // Immediate as operand two
        logic  regWe;
        logic  memRd;                                      // Write-back from memory
        logic  memWe;
        pcSelE pcSel;
    } ctrlT;

    // ================================================
    // Instruction word, two overlapping views
    // ================================================
    typedef struct packed {
        opcodeE                opcode;                     // 31:24
        logic [4:0]            rsvd1;
        logic [REG_ADDR_W-1:0] dest;                       // 18:16
        logic [4:0]            rsvd0;
        logic [REG_ADDR_W-1:0] src1;                       // 10:8
        logic [DATA_W-1:0]     src2Imm;                    // Immediate, or src2 in 2:0
    } arithT;

    typedef struct packed {
        opcodeE            opcode;
        logic [DATA_W-1:0] offset;                         // 23:16, in words
        logic [15:0]       unused;
    } branchT;

    typedef union packed {
        arithT  arith;
        branchT branch;
    } instrU;

    typedef struct packed {
        logic                  enable;
        logic [REG_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     data;
    } regWriteT;

    typedef struct packed {
        logic              enable;
        logic [DATA_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } memWriteT;

endpackage

// File: src/instrDecoder.sv
/* Opcode to control word table */
`timescale 1ns/100ps

module instrDecoder import cpuPkg::*; (
    input  logic   RESET,
    input  opcodeE opcode,
    output ctrlT   ctrl
);

    // Packs one table row
    function automatic ctrlT mkCtrl(
        input aluOpE aluOp,
        input logic  negate,
        input logic  useImm,
        input logic  regWe,
        input logic  memRd,
        input logic  memWe,
        input pcSelE pcSel
    );
        ctrlT c;
        c.aluOp  = aluOp;
        c.negate = negate;
        c.useImm = useImm;
        c.regWe  = regWe;
        c.memRd  = memRd;
        c.memWe  = memWe;
        c.pcSel  = pcSel;
        return c;
    endfunction

    // ================================================
    // Decode table
    // ================================================
    //                                  alu      neg   imm   rwe   mrd   mwe   pc
    always_comb begin
        ctrl = '0;                                         // No-op word
        if (!RESET) begin
            case (opcode)
                OP_LOADI: ctrl = mkCtrl(ALU_FWD, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, PC_SEQ);
                OP_MOV:   ctrl = mkCtrl(ALU_FWD, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, PC_SEQ);
                OP_ADD:   ctrl = mkCtrl(ALU_ADD, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, PC_SEQ);
                OP_SUB:   ctrl = mkCtrl(ALU_ADD, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, PC_SEQ);
                OP_AND:   ctrl = mkCtrl(ALU_AND, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, PC_SEQ);
                OP_OR:    ctrl = mkCtrl(ALU_OR,  1'b0, 1'b0, 1'b1, 1'b0, 1'b0, PC_SEQ);
                // Branches write nothing
                OP_J:     ctrl = mkCtrl(ALU_ADD, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, PC_JUMP);
                OP_BEQ:   ctrl = mkCtrl(ALU_ADD, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, PC_BEQ);
                // Loads: address is forwarded operand two
                OP_LWD:   ctrl = mkCtrl(ALU_FWD, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, PC_SEQ);
                OP_LWI:   ctrl = mkCtrl(ALU_FWD, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, PC_SEQ);
                // Stores take data from src1
                OP_SWD:   ctrl = mkCtrl(ALU_FWD, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, PC_SEQ);
                OP_SWI:   ctrl = mkCtrl(ALU_FWD, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, PC_SEQ);
                default:  ctrl = '0;                       // Unknown opcode
            endcase
        end
    end

endmodule

// File: src/regFile.sv
/* Eight-entry register file, two read ports and one write port */
`timescale 1ns/100ps

module regFile import cpuPkg::*; (
    input  logic                  CLK,
    input  logic                  RESET,
    input  regWriteT              wr,
    input  logic [REG_ADDR_W-1:0] rdAddr1,
    input  logic [REG_ADDR_W-1:0] rdAddr2,
    output logic [DATA_W-1:0]     rdData1,
    output logic [DATA_W-1:0]     rdData2
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [DATA_W-1:0] regs [NUM_REGS];                    // Architectural registers

    // Reads are combinational
    assign rdData1 = regs[rdAddr1];
    assign rdData2 = regs[rdAddr2];

    // ================================================
    // Clocked write
    // ================================================
    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;                             // All registers to zero
            end
        end else if (wr.enable) begin
            regs[wr.addr] <= wr.data;
        end
    end

endmodule

// File: src/executeUnit.sv
/* Operand two selection, ALU operations and zero flag */
`timescale 1ns/100ps

module executeUnit import cpuPkg::*; (
    input  ctrlT              ctrl,
    input  logic [DATA_W-1:0] opA,                         // Register src1
    input  logic [DATA_W-1:0] opB,                         // Register src2
    input  logic [DATA_W-1:0] imm,
    output logic [DATA_W-1:0] aluResult,
    output logic              zero
);

    logic [DATA_W-1:0] opBNeg;                             // Two's complement of opB
    logic [DATA_W-1:0] opBSel;                             // After negate mux
    logic [DATA_W-1:0] opTwo;                              // After immediate mux

    assign opBNeg = ~opB + 1'b1;                           // sub and beq run as add
    assign opBSel = ctrl.negate ? opBNeg : opB;
    assign opTwo  = ctrl.useImm ? imm : opBSel;

    // ================================================
    // ALU
    // ================================================
    always_comb begin
        aluResult = opTwo;                                 // Forward by default
        case (ctrl.aluOp)
            ALU_FWD: aluResult = opTwo;                    // loadi, mov, loads, stores
            ALU_ADD: aluResult = opA + opTwo;              // Wraps modulo 256
            ALU_AND: aluResult = opA & opTwo;
            ALU_OR:  aluResult = opA | opTwo;
            default: aluResult = opTwo;
        endcase
    end

    // Equal operands give zero on a subtract
    assign zero = (aluResult == '0);

endmodule

// File: src/pcUnit.sv
/* Program counter register, branch target and next-PC choice */
`timescale 1ns/100ps

module pcUnit import cpuPkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  pcSelE             pcSel,
    input  logic              zero,
    input  logic [DATA_W-1:0] offset,                      // Signed word offset
    output logic [PC_W-1:0]   pc
);

    logic [PC_W-1:0] pcPlus;                               // Sequential address
    logic [PC_W-1:0] offsetExt;                            // Sign-extended, times 4
    logic [PC_W-1:0] target;
    logic [PC_W-1:0] pcNext;

    assign pcPlus    = pc + PC_W'(PC_STEP);
    assign offsetExt = {{(PC_W-DATA_W-2){offset[DATA_W-1]}}, offset, 2'b00};
    assign target    = pcPlus + offsetExt;                 // Relative to next instruction

    // ================================================
    // Next PC
    // ================================================
    always_comb begin
        pcNext = pcPlus;
        case (pcSel)
            PC_JUMP: pcNext = target;                      // Unconditional
            PC_BEQ: begin
                if (zero) begin
                    pcNext = target;                       // Taken when equal
                end
            end
            default: pcNext = pcPlus;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

// File: src/dataMemory.sv
/* Byte-wide data memory, combinational read and clocked write */
`timescale 1ns/100ps

module dataMemory #(
    parameter int DMEM_ADDR_W = 8
) (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       we,
    input  logic [7:0] addr,                               // Low DMEM_ADDR_W bits used
    input  logic [7:0] wrData,
    output logic [7:0] rdData
);

    localparam int DEPTH = 2 ** DMEM_ADDR_W;

    logic [7:0] mem [DEPTH];

    assign rdData = mem[addr[DMEM_ADDR_W-1:0]];            // Same-cycle read

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;                              // Clear every byte
            end
        end else if (we) begin
            mem[addr[DMEM_ADDR_W-1:0]] <= wrData;
        end
    end

endmodule

// File: src/cpuCore.sv
/* Single-cycle core top level: decoder, register file, ALU, data memory,
   PC logic and write-back mux */
`timescale 1ns/100ps

module cpuCore import cpuPkg::*; #(
    parameter int DMEM_ADDR_W = 8
) (
    input  logic            CLK,
    input  logic            RESET,
    input  instrU           instruction,
    output logic [PC_W-1:0] pc,
    output regWriteT        regWrite,                      // Register file write port
    output memWriteT        memWrite                       // Data memory write port
);

    ctrlT              ctrl;
    logic [DATA_W-1:0] rdData1;                            // src1, also store data
    logic [DATA_W-1:0] rdData2;                            // src2
    logic [DATA_W-1:0] aluResult;                          // ALU value or memory address
    logic              zero;
    logic [DATA_W-1:0] rdData;                             // Memory read data

    instrDecoder u_decoder (.RESET(RESET), .opcode(instruction.arith.opcode), .ctrl(ctrl));

    regFile u_regFile (
        .CLK(CLK), .RESET(RESET), .wr(regWrite),
        .rdAddr1(instruction.arith.src1),
        .rdAddr2(instruction.arith.src2Imm[REG_ADDR_W-1:0]),  // src2 in low bits
        .rdData1(rdData1), .rdData2(rdData2)
    );

    executeUnit u_execute (
        .ctrl(ctrl), .opA(rdData1), .opB(rdData2), .imm(instruction.arith.src2Imm),
        .aluResult(aluResult), .zero(zero)
    );

    dataMemory #(.DMEM_ADDR_W(DMEM_ADDR_W)) u_dataMem (
        .CLK(CLK), .RESET(RESET), .we(memWrite.enable), .addr(memWrite.addr),
        .wrData(memWrite.data), .rdData(rdData)
    );

    pcUnit u_pcUnit (
        .CLK(CLK), .RESET(RESET), .pcSel(ctrl.pcSel), .zero(zero),
        .offset(instruction.branch.offset), .pc(pc)
    );

    // ================================================
    // Write ports
    // ================================================
    assign regWrite.enable = ctrl.regWe;
    assign regWrite.addr   = instruction.arith.dest;
    assign regWrite.data   = ctrl.memRd ? rdData : aluResult;  // Load or ALU value
    assign memWrite.enable = ctrl.memWe;
    assign memWrite.addr   = aluResult;
    assign memWrite.data   = rdData1;

endmodule

// File: test/cpuCore_chk.sv
/* Bound assertions: write ports quiet in reset, pc after reset, pc alignment */
`timescale 1ns/100ps

module cpuCore_chk import cpuPkg::*; (
    input logic            CLK,
    input logic            RESET,
    input logic [PC_W-1:0] pc,
    input regWriteT        regWrite,
    input memWriteT        memWrite
);

    int failCount = 0;                                     // Read by the testbench

    // ================================================
    // Properties
    // ================================================
    noWriteInReset: assert property (@(posedge CLK)
        RESET |-> !regWrite.enable && !memWrite.enable)    // Decoder gives a no-op word
        else begin
            $error("write enable active while RESET is high");
            failCount++;
        end

    pcZeroAfterReset: assert property (@(posedge CLK) $fell(RESET) |-> pc == '0)
        else begin
            $error("pc not zero in the first cycle after reset");
            failCount++;
        end

    pcAligned: assert property (@(posedge CLK) disable iff (RESET) pc[1:0] == 2'b00)
        else begin
            $error("pc not a multiple of 4");
            failCount++;
        end

endmodule

// File: test/cpuScoreboard.sv
/* Reference model of the core, compared with pc and both write ports each cycle */
`timescale 1ns/100ps

module cpuScoreboard import cpuPkg::*; (
    input  logic            CLK,
    input  logic            RESET,
    input  instrU           instruction,
    input  logic [PC_W-1:0] pc,
    input  regWriteT        regWrite,
    input  memWriteT        memWrite,
    output int              errorCount,
    output int              checkCount
);

    logic [7:0]  modelRegs [8];
    logic [7:0]  modelMem [256];
    logic [31:0] modelPc = '0;
    logic [31:0] expPc   = '0;                             // Next pc
    regWriteT    expReg  = '0;
    memWriteT    expMem  = '0;
    int          errs    = 0;
    int          checks  = 0;

    assign errorCount = errs;
    assign checkCount = checks;

    task automatic flagMismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        errs++;
    endtask

    // Expected commit of the current instruction
    task automatic predict();
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  imm;
        logic [7:0]  off;
        logic [2:0]  dest;
        logic [31:0] takenPc;
        a       = modelRegs[instruction.arith.src1];
        b       = modelRegs[instruction.arith.src2Imm[2:0]];
        imm     = instruction.arith.src2Imm;
        dest    = instruction.arith.dest;
        off     = instruction.branch.offset;
        takenPc = modelPc + 32'd4 + ({{24{off[7]}}, off} << 2);  // Word offset
        expReg  = '0;
        expMem  = '0;
        expPc   = modelPc + 32'd4;
        case (instruction.arith.opcode)
            OP_LOADI: expReg = {1'b1, dest, imm};
            OP_MOV:   expReg = {1'b1, dest, b};
            OP_ADD:   expReg = {1'b1, dest, a + b};        // Wraps in 8 bits
            OP_SUB:   expReg = {1'b1, dest, a - b};
            OP_AND:   expReg = {1'b1, dest, a & b};
            OP_OR:    expReg = {1'b1, dest, a | b};
            OP_J:     expPc  = takenPc;
            OP_BEQ: begin
                if (a == b) begin
                    expPc = takenPc;
                end
            end
            OP_LWD:   expReg = {1'b1, dest, modelMem[b]};
            OP_LWI:   expReg = {1'b1, dest, modelMem[imm]};
            OP_SWD:   expMem = {1'b1, b, a};               // Data from src1
            OP_SWI:   expMem = {1'b1, imm, a};
            default: ;                                     // Opcodes 12 and up
        endcase
    endtask

    // ================================================
    // Compare on the falling edge
    // ================================================
    always @(negedge CLK) begin
        if (RESET) begin
            if (regWrite.enable || memWrite.enable) begin
                flagMismatch("write enable active during reset");
            end
        end else begin
            predict();
            checks++;
            if (pc !== modelPc) begin
                flagMismatch($sformatf("pc %h, expected %h", pc, modelPc));
            end
            if (regWrite.enable !== expReg.enable || (expReg.enable && regWrite !== expReg)) begin
                flagMismatch($sformatf("regWrite %h, expected %h", regWrite, expReg));
            end
            if (memWrite.enable !== expMem.enable || (expMem.enable && memWrite !== expMem)) begin
                flagMismatch($sformatf("memWrite %h, expected %h", memWrite, expMem));
            end
        end
    end

    // Model state commits with the DUT
    always @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < 8; i++) begin
                modelRegs[i] = '0;
            end
            for (int i = 0; i < 256; i++) begin
                modelMem[i] = '0;
            end
            modelPc = '0;
        end else begin
            if (expReg.enable) begin
                modelRegs[expReg.addr] = expReg.data;
            end
            if (expMem.enable) begin
                modelMem[expMem.addr] = expMem.data;
            end
            modelPc = expPc;
        end
    end

endmodule

// File: test/tbCpu.sv
/* Testbench top with clock, reset, random programs, instruction drive,
   test sequence, watchdog and verdict */
`timescale 1ns/100ps

module tbCpu import cpuPkg::*; ();

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 16;
    localparam int          RUN_CYCLES   = 300;
    localparam int          NUM_TESTS    = 4;
    localparam int          WATCHDOG     = NUM_TESTS * (RUN_CYCLES + RESET_CYCLES) + 100;
    localparam logic [31:0] SEED         = 32'h91cb;

    logic            CLK = 1'b0;                           // Low before time 0, no edge at start
    logic            RESET;
    instrU           instruction;
    logic [PC_W-1:0] pc;
    regWriteT        regWrite;
    memWriteT        memWrite;
    int              errorCount;                           // From scoreboard
    int              checkCount;
    logic [31:0]     progMem [64];                         // Indexed by pc[7:2]

    cpuCore #(.DMEM_ADDR_W(8)) cpuCore_inst (
        .CLK(CLK), .RESET(RESET), .instruction(instruction),
        .pc(pc), .regWrite(regWrite), .memWrite(memWrite)
    );

    cpuScoreboard scoreboard (
        .CLK(CLK), .RESET(RESET), .instruction(instruction), .pc(pc),
        .regWrite(regWrite), .memWrite(memWrite),
        .errorCount(errorCount), .checkCount(checkCount)
    );

    bind cpuCore cpuCore_chk chkInst (
        .CLK(CLK), .RESET(RESET), .pc(pc), .regWrite(regWrite), .memWrite(memWrite)
    );

    initial begin
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // Instruction fetch 1 ns after each edge
    initial begin
        forever begin
            @(posedge CLK);
            #1;
            instruction = progMem[pc[7:2]];                // (pc/4) mod 64
        end
    end

    initial begin
        #(WATCHDOG * CLK_PERIOD);
        $display("Watchdog expired: the tests did not finish within %0d cycles", WATCHDOG);
        $display("Test failed");
        $finish;
    end

    // Random word with an opcode from one test's mix
    function automatic logic [31:0] randInstr(input int mix);
        logic [31:0] word;
        logic [7:0]  op;
        word = $urandom;
        op   = 8'($urandom_range(0, 5));                   // Arithmetic group
        case (mix)
            1: begin                                       // Control flow
                op = ($urandom_range(0, 3) < 2) ? OP_LOADI : 8'($urandom_range(OP_J, OP_BEQ));
                word[7:0] = 8'($urandom_range(0, 3));      // Few values so beq is often equal
            end
            2: begin                                       // Memory
                op = 8'($urandom_range(OP_LWD, OP_SWI + 1));
                if (op > OP_SWI) begin
                    op = OP_LOADI;
                end
                word[7:0] = 8'($urandom_range(0, 15));     // Small address window
            end
            3: begin                                       // No-ops among arithmetic
                if ($urandom_range(0, 1) == 1) begin
                    op = 8'($urandom_range(12, 255));
                end
            end
            default: ;
        endcase
        return {op, word[23:0]};
    endfunction

    task automatic runTest(input int mix, input string name);
        int errBefore;
        int checkBefore;
        @(posedge CLK);
        #1;
        RESET = 1'b1;                                      // Fresh core per test
        for (int i = 0; i < 64; i++) begin
            progMem[i] = randInstr(mix);
        end
        errBefore = errorCount;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        RESET = 1'b0;
        checkBefore = checkCount;
        repeat (RUN_CYCLES) @(posedge CLK);
        $display("test %-8s %0d cycles checked, %0d errors", name,
                 checkCount - checkBefore, errorCount - errBefore);
    endtask

    // ================================================
    // Test sequence
    // ================================================
    initial begin
        int assertFails;
        void'($urandom(SEED));
        RESET       = 1'b1;
        instruction = '0;
        runTest(0, "arith");
        runTest(1, "control");
        runTest(2, "memory");
        runTest(3, "noop");
        assertFails = cpuCore_inst.chkInst.failCount;
        $display("%0d tests, %0d cycles checked, %0d mismatches, %0d assertion failures",
                 NUM_TESTS, checkCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0 && checkCount > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: project.f
src/cpuPkg.sv
src/instrDecoder.sv
src/regFile.sv
src/executeUnit.sv
src/pcUnit.sv
src/dataMemory.sv
src/cpuCore.sv
test/cpuCore_chk.sv
test/cpuScoreboard.sv
test/tbCpu.sv

// File: Makefile
TOP = tbCpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f -o simv
	./obj_dir/simv +verilator+error+limit+1000 | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
